// File: rtl/noc_msg_pkg.sv
package noc_msg_pkg;

    // ********************
    // flit and field widths
    // ********************

    localparam int NOC_DATA_W = 64;       // one flit.
    localparam int XY_W       = 4;        // mesh coordinate.
    localparam int FBITS_W    = 4;        // endpoint selector inside a tile.
    localparam int MSG_LEN_W  = 8;        // body flits after the header.

    // ********************
    // message types
    // ********************

    typedef enum logic [7:0] {
        TCP_RX_MSG_REQ  = 8'h40,          // app asks for notifications.
        TCP_RX_MSG_RESP = 8'h41           // notification back to the app.
    } msg_type_e;

    // ********************
    // header flit core
    // ********************

    // common to every message on the mesh, dst first so the
    // routers find it in the top bits.
    typedef struct packed {
        logic [XY_W-1:0]      dst_x_coord;
        logic [XY_W-1:0]      dst_y_coord;
        logic [FBITS_W-1:0]   dst_fbits;
        logic [MSG_LEN_W-1:0] msg_len;    // zero for single flit messages.
        msg_type_e            msg_type;
        logic [XY_W-1:0]      src_x_coord;
        logic [XY_W-1:0]      src_y_coord;
        logic [FBITS_W-1:0]   src_fbits;
    } noc_hdr_core_s;

    // a tile endpoint.
    typedef struct packed {
        logic [XY_W-1:0]      x;
        logic [XY_W-1:0]      y;
        logic [FBITS_W-1:0]   fbits;
    } noc_dest_s;

endpackage

// File: rtl/tcp_rx_pkg.sv
package tcp_rx_pkg;
    import noc_msg_pkg::*;

    // ********************
    // flows and buffers
    // ********************

    localparam int NUM_FLOWS = 8;
    localparam int FLOWID_W  = 3;         // log2 of NUM_FLOWS.
    localparam int BUF_IDX_W = 8;
    localparam int BUF_LEN_W = 12;

    typedef struct packed {
        logic [BUF_IDX_W-1:0] idx;        // slot in the payload buffer.
        logic [BUF_LEN_W-1:0] len;        // bytes of in-order data.
    } tcp_buf_with_idx;

    // from the receive pipeline.
    typedef struct packed {
        logic [FLOWID_W-1:0]  flowid;
        tcp_buf_with_idx      head_buf;
        noc_dest_s            dst;        // owning app tile.
    } tcp_rx_commit_s;

    // poller to output side.
    typedef struct packed {
        logic [FLOWID_W-1:0]  flowid;
        tcp_buf_with_idx      head_buf;
        noc_dest_s            dst;
    } tcp_rx_pick_s;

    // ********************
    // notification flit
    // ********************

    localparam int HDR_PAD_W = NOC_DATA_W - $bits(noc_hdr_core_s) - FLOWID_W
                             - $bits(tcp_buf_with_idx);

    typedef struct packed {
        noc_hdr_core_s        core;
        logic [FLOWID_W-1:0]  inner_flowid;
        tcp_buf_with_idx      inner_buf;
        logic [HDR_PAD_W-1:0] pad;        // unused low bits.
    } tcp_noc_hdr_flit;

    localparam logic [FBITS_W-1:0] TCP_RX_APP_PTR_IF_FBITS = 4'h3;

endpackage

// File: rtl/tcp_rx_flow_ready_tbl.sv
module tcp_rx_flow_ready_tbl
    import tcp_rx_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         commit_val,
    output logic                         commit_rdy,
    input  tcp_rx_commit_s               commit,

    input  logic                         clr_val,
    input  logic [FLOWID_W-1:0]          clr_flowid,

    output logic [NUM_FLOWS-1:0]         pending,
    output tcp_rx_pick_s [NUM_FLOWS-1:0] flow_data
);

    logic commit_xfer;
    logic rdy_reg;

    assign commit_rdy  = rdy_reg;
    assign commit_xfer = commit_val & commit_rdy;

    // ********************
    // commit acceptance
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_reg <= 1'b0;
        end else begin
            rdy_reg <= 1'b1;                     // open once out of reset.
        end
    end

    // ********************
    // pending bitmap
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (clr_val) begin
                pending[clr_flowid] <= 1'b0;
            end
            // the set comes last so a commit landing on the flow being
            // picked in this cycle is kept for the next round.
            if (commit_xfer) begin
                pending[commit.flowid] <= 1'b1;
            end
        end
    end

    // ********************
    // per flow fields
    // ********************

    always_ff @(posedge clk) begin
        if (commit_xfer) begin
            flow_data[commit.flowid].flowid   <= commit.flowid;
            flow_data[commit.flowid].head_buf <= commit.head_buf;  // latest wins.
            flow_data[commit.flowid].dst      <= commit.dst;
        end
    end

    // poller only clears what it saw pending.
    clr_only_pending: assert property (
        @(posedge clk) disable iff (rst)
        clr_val |-> pending[clr_flowid]
    );

endmodule

// File: rtl/tcp_rx_poller.sv
module tcp_rx_poller
    import tcp_rx_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    input  logic [NUM_FLOWS-1:0]         pending,
    input  tcp_rx_pick_s [NUM_FLOWS-1:0] flow_data,

    output logic                         pick_val,
    input  logic                         pick_rdy,
    output tcp_rx_pick_s                 pick,

    output logic                         clr_val,
    output logic [FLOWID_W-1:0]          clr_flowid
);

    logic [FLOWID_W-1:0] ptr;                    // first flow to look at.
    logic [FLOWID_W-1:0] grant_idx;
    logic                found;

    // ********************
    // round robin search
    // ********************

    always_comb begin
        logic [FLOWID_W-1:0] cand;

        found     = 1'b0;
        grant_idx = '0;
        cand      = '0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            cand = ptr + FLOWID_W'(i);           // wraps at NUM_FLOWS.
            if (!found && pending[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign pick_val   = found;
    assign pick       = flow_data[grant_idx];
    assign clr_val    = pick_val & pick_rdy;
    assign clr_flowid = grant_idx;

    // ********************
    // pointer
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (clr_val) begin
            ptr <= grant_idx + 1'b1;             // one past the last grant.
        end
    end

    // the table row behind the pick must still be pending.
    pick_is_pending: assert property (
        @(posedge clk) disable iff (rst)
        pick_val |-> pending[pick.flowid]
    );

endmodule

// File: rtl/tcp_rx_msg_noc_if_out_ctrl.sv
module tcp_rx_msg_noc_if_out_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic pick_val,
    output logic pick_rdy,

    output logic noc_out_val,
    input  logic noc_out_rdy,

    output logic ctrl_datap_store_inputs
);

    typedef enum logic [0:0] {
        WAIT_PICK,
        SEND_HDR
    } state_e;

    state_e state;
    state_e state_next;

    // ********************
    // state register
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_PICK;
        end else begin
            state <= state_next;
        end
    end

    // ********************
    // next state, outputs
    // ********************

    always_comb begin
        state_next              = state;
        pick_rdy                = 1'b0;
        noc_out_val             = 1'b0;
        ctrl_datap_store_inputs = 1'b0;
        case (state)
            WAIT_PICK: begin
                pick_rdy = pick_val;             // only when there is a pick.
                if (pick_val) begin
                    ctrl_datap_store_inputs = 1'b1;
                    state_next              = SEND_HDR;
                end
            end
            SEND_HDR: begin
                noc_out_val = 1'b1;              // held until the mesh takes it.
                if (noc_out_rdy) begin
                    state_next = WAIT_PICK;
                end
            end
            default: begin
                state_next = WAIT_PICK;
            end
        endcase
    end

    // a store is followed by the flit on the very next cycle.
    store_then_send: assert property (
        @(posedge clk) disable iff (rst)
        ctrl_datap_store_inputs |-> (state == WAIT_PICK) ##1 noc_out_val
    );

endmodule

// File: rtl/tcp_rx_msg_noc_if_out_datap.sv
module tcp_rx_msg_noc_if_out_datap
    import noc_msg_pkg::*;
    import tcp_rx_pkg::*;
#(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  tcp_rx_pick_s          pick,
    input  logic                  ctrl_datap_store_inputs,

    output logic [NOC_DATA_W-1:0] noc_out_data
);

    logic [FLOWID_W-1:0] flowid_reg;
    tcp_buf_with_idx     head_buf_reg;
    noc_dest_s           dst_reg;
    tcp_noc_hdr_flit     hdr_flit;

    // ********************
    // pick registers
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            flowid_reg   <= '0;
            head_buf_reg <= '0;
            dst_reg      <= '0;
        end else if (ctrl_datap_store_inputs) begin
            flowid_reg   <= pick.flowid;
            head_buf_reg <= pick.head_buf;
            dst_reg      <= pick.dst;
        end
    end

    // ********************
    // header flit
    // ********************

    always_comb begin
        hdr_flit = '0;

        hdr_flit.core.dst_x_coord = dst_reg.x;
        hdr_flit.core.dst_y_coord = dst_reg.y;
        hdr_flit.core.dst_fbits   = dst_reg.fbits;
        hdr_flit.core.msg_len     = '0;          // header only.
        hdr_flit.core.msg_type    = TCP_RX_MSG_RESP;
        hdr_flit.core.src_x_coord = XY_W'(SRC_X);
        hdr_flit.core.src_y_coord = XY_W'(SRC_Y);
        hdr_flit.core.src_fbits   = TCP_RX_APP_PTR_IF_FBITS;

        hdr_flit.inner_flowid     = flowid_reg;
        hdr_flit.inner_buf        = head_buf_reg;
    end

    assign noc_out_data = hdr_flit;

endmodule

// File: rtl/tcp_rx_notif_top.sv
module tcp_rx_notif_top
    import noc_msg_pkg::*;
    import tcp_rx_pkg::*;
#(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  commit_val,
    output logic                  commit_rdy,
    input  tcp_rx_commit_s        commit,

    output logic                  noc_out_val,
    input  logic                  noc_out_rdy,
    output logic [NOC_DATA_W-1:0] noc_out_data
);

    logic [NUM_FLOWS-1:0]         pending;
    tcp_rx_pick_s [NUM_FLOWS-1:0] flow_data;

    logic                         pick_val;
    logic                         pick_rdy;
    tcp_rx_pick_s                 pick;

    logic                         clr_val;
    logic [FLOWID_W-1:0]          clr_flowid;
    logic                         ctrl_datap_store_inputs;

    tcp_rx_flow_ready_tbl flow_tbl (
        .clk        (clk),
        .rst        (rst),
        .commit_val (commit_val),
        .commit_rdy (commit_rdy),
        .commit     (commit),
        .clr_val    (clr_val),
        .clr_flowid (clr_flowid),
        .pending    (pending),
        .flow_data  (flow_data)
    );

    tcp_rx_poller poller (
        .clk        (clk),
        .rst        (rst),
        .pending    (pending),
        .flow_data  (flow_data),
        .pick_val   (pick_val),
        .pick_rdy   (pick_rdy),
        .pick       (pick),
        .clr_val    (clr_val),
        .clr_flowid (clr_flowid)
    );

    tcp_rx_msg_noc_if_out_ctrl out_ctrl (
        .clk                     (clk),
        .rst                     (rst),
        .pick_val                (pick_val),
        .pick_rdy                (pick_rdy),
        .noc_out_val             (noc_out_val),
        .noc_out_rdy             (noc_out_rdy),
        .ctrl_datap_store_inputs (ctrl_datap_store_inputs)
    );

    tcp_rx_msg_noc_if_out_datap #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) out_datap (
        .clk                     (clk),
        .rst                     (rst),
        .pick                    (pick),
        .ctrl_datap_store_inputs (ctrl_datap_store_inputs),
        .noc_out_data            (noc_out_data)
    );

endmodule

// File: testbench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;                       // 4 ns period.
        end
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;                           // released like the other inputs.
    end

endmodule

// File: testbench/tb_tcp_rx_notif.sv
module tb_tcp_rx_notif
    import noc_msg_pkg::*;
    import tcp_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst;
    logic                  commit_val;
    logic                  commit_rdy;
    tcp_rx_commit_s        commit;
    logic                  noc_out_val;
    logic                  noc_out_rdy;
    logic [NOC_DATA_W-1:0] noc_out_data;

    logic [31:0]           lfsr = 32'hb9a97aa6;

    // reference model state.
    tcp_rx_commit_s        m_data [NUM_FLOWS];
    logic [NUM_FLOWS-1:0]  m_pending;
    logic                  m_busy;                // a flit is being offered.
    int                    m_ptr;
    logic [NOC_DATA_W-1:0] exp_flit;
    logic                  commit_seen = 1'b0;
    int                    picks_made;
    int                    flits_sent;

    tb_clk_gen clk_gen (
        .clk (clk),
        .rst (rst)
    );

    tcp_rx_notif_top #(
        .SRC_X (2),
        .SRC_Y (1)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .commit_val   (commit_val),
        .commit_rdy   (commit_rdy),
        .commit       (commit),
        .noc_out_val  (noc_out_val),
        .noc_out_rdy  (noc_out_rdy),
        .noc_out_data (noc_out_data)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1);
    endtask

    // ********************
    // random bits
    // ********************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;      // taps 32, 22, 2, 1.
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // ********************
    // reference model
    // ********************

    function automatic int next_flow(input logic [NUM_FLOWS-1:0] pend, input int start);
        int idx;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            idx = (start + i) % NUM_FLOWS;
            if (pend[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic logic [NOC_DATA_W-1:0] expected_flit(input tcp_rx_commit_s c);
        tcp_noc_hdr_flit f;
        f = '0;
        f.core.dst_x_coord = c.dst.x;
        f.core.dst_y_coord = c.dst.y;
        f.core.dst_fbits   = c.dst.fbits;
        f.core.msg_type    = TCP_RX_MSG_RESP;
        f.core.src_x_coord = 4'd2;               // tile of this block.
        f.core.src_y_coord = 4'd1;
        f.core.src_fbits   = TCP_RX_APP_PTR_IF_FBITS;
        f.inner_flowid     = c.flowid;
        f.inner_buf        = c.head_buf;
        return f;
    endfunction

    always @(posedge clk) begin
        logic [NUM_FLOWS-1:0] nxt_pending;
        int                   sel;

        if (rst) begin
            m_pending  <= '0;
            m_busy     <= 1'b0;
            m_ptr      <= 0;
            picks_made <= 0;
            flits_sent <= 0;
        end else begin
            nxt_pending = m_pending;
            sel         = -1;
            if (noc_out_val && noc_out_rdy) begin
                flits_sent <= flits_sent + 1;
            end
            if (m_busy && noc_out_rdy) begin
                m_busy <= 1'b0;
            end
            if (!m_busy) begin
                sel = next_flow(m_pending, m_ptr);
            end
            if (sel >= 0) begin
                exp_flit         <= expected_flit(m_data[sel]);
                nxt_pending[sel] = 1'b0;
                m_ptr            <= (sel + 1) % NUM_FLOWS;
                m_busy           <= 1'b1;
                picks_made       <= picks_made + 1;
            end
            if (commit_val && commit_rdy) begin
                nxt_pending[commit.flowid] = 1'b1;  // set after clear.
                m_data[commit.flowid]      <= commit;
                commit_seen                <= 1'b1;
            end
            m_pending <= nxt_pending;
        end
    end

    // ********************
    // checks
    // ********************

    idle_before_commit: assert property (@(posedge clk) !commit_seen |-> !noc_out_val)
        else stop_run($sformatf("FAILED at %0t: flit sent before any commit", $time));

    ready_after_reset: assert property (
        @(posedge clk) disable iff (rst) $past(!rst) |-> commit_rdy
    ) else stop_run($sformatf("FAILED at %0t: commit_rdy low after reset", $time));

    val_matches_model: assert property (
        @(posedge clk) disable iff (rst) noc_out_val == m_busy
    ) else stop_run($sformatf("FAILED at %0t: noc_out_val differs from the model", $time));

    data_matches_model: assert property (
        @(posedge clk) disable iff (rst) noc_out_val |-> noc_out_data == exp_flit
    ) else stop_run($sformatf("FAILED at %0t: flit %h, expected %h", $time,
                              $sampled(noc_out_data), $sampled(exp_flit)));

    held_flit_stable: assert property (
        @(posedge clk) disable iff (rst)
        noc_out_val && !noc_out_rdy |=> noc_out_val && $stable(noc_out_data)
    ) else stop_run($sformatf("FAILED at %0t: held flit changed before accept", $time));

    // ********************
    // stimulus
    // ********************

    task automatic idle_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic commit_flow(input logic [FLOWID_W-1:0] fid);
        logic [31:0] r;
        int          n;

        commit.flowid = fid;
        take_bits(BUF_IDX_W, r);
        commit.head_buf.idx = r[BUF_IDX_W-1:0];
        take_bits(BUF_LEN_W, r);
        commit.head_buf.len = r[BUF_LEN_W-1:0];
        take_bits(12, r);
        commit.dst = r[11:0];
        commit_val = 1'b1;
        n = 0;
        while (!commit_rdy) begin
            idle_cycle();
            n++;
            if (n > 20) begin
                stop_run("timeout waiting for commit_rdy");
            end
        end
        idle_cycle();
        commit_val = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (m_pending != '0 || m_busy) begin
            idle_cycle();
            n++;
            if (n > 100) begin
                stop_run("timeout waiting for all notifications to leave");
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        int          n;

        commit_val  = 1'b0;
        commit      = '0;
        noc_out_rdy = 1'b0;

        n = 0;
        while (rst) begin
            idle_cycle();
            n++;
            if (n > 20) begin
                stop_run("timeout waiting for reset to be released");
            end
        end
        repeat (4) idle_cycle();

        noc_out_rdy = 1'b1;                      // one commit, mesh ready.
        commit_flow(3'd5);
        wait_drained();

        repeat (80) begin
            take_bits(3, r);
            noc_out_rdy = r[0] & r[1];           // mostly stalled.
            if (r[2]) begin
                take_bits(FLOWID_W, r);
                commit_flow(r[FLOWID_W-1:0]);
            end else begin
                idle_cycle();
            end
        end
        noc_out_rdy = 1'b1;
        wait_drained();

        noc_out_rdy = 1'b0;                      // burst behind a stalled mesh.
        commit_flow(3'd1);
        commit_flow(3'd6);
        commit_flow(3'd3);
        commit_flow(3'd0);
        repeat (3) idle_cycle();
        noc_out_rdy = 1'b1;
        wait_drained();

        noc_out_rdy = 1'b0;                      // flow 2 twice while 7 is held.
        commit_flow(3'd7);
        commit_flow(3'd2);
        commit_flow(3'd2);
        repeat (3) idle_cycle();
        noc_out_rdy = 1'b1;
        wait_drained();
        repeat (4) idle_cycle();

        if (flits_sent == picks_made && flits_sent > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_run($sformatf("FAILED at %0t: %0d flits sent for %0d picks", $time,
                               flits_sent, picks_made));
        end
    end

endmodule

// File: tcp_rx_notif_top.f
rtl/noc_msg_pkg.sv
rtl/tcp_rx_pkg.sv
rtl/tcp_rx_flow_ready_tbl.sv
rtl/tcp_rx_poller.sv
rtl/tcp_rx_msg_noc_if_out_ctrl.sv
rtl/tcp_rx_msg_noc_if_out_datap.sv
rtl/tcp_rx_notif_top.sv
testbench/tb_clk_gen.sv
testbench/tb_tcp_rx_notif.sv

// File: Makefile
TOP := tb_tcp_rx_notif

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --top-module $(TOP) -f tcp_rx_notif_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
